/* hw/mcp_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_core
    import mcp_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cid,
    input  logic                run,
    output logic                halted,
    output logic [IADDR_W-1:0]  fetch_addr,
    input  logic [DATA_W-1:0]   fetch_data,
    output logic                dm_req,
    output dmem_req_t           dm_req_data,
    input  logic                dm_ack,
    input  dmem_rsp_t           dm_rsp
);

    core_state_e        state;
    logic [IADDR_W-1:0] pc;
    opcode_e            ir;
    opcode_e            dec_op;
    logic [DATA_W-1:0]  opnd;
    logic [DATA_W-1:0]  ac;
    logic [DATA_W-1:0]  r;
    logic [DATA_W-1:0]  a;
    logic [DATA_W-1:0]  b;
    logic [DATA_W-1:0]  c;
    logic [DATA_W-1:0]  d;
    logic               has_opnd;
    logic               is_mem;

    assign dec_op   = opcode_e'(fetch_data);
    assign has_opnd = dec_op inside {LDAC, JPNZ};
    assign is_mem   = dec_op inside {LDDAC, STDAC};

    assign fetch_addr = pc;
    assign halted     = (state == HALT);

    // ------------------------------------------------------------------
    // data handshake, held stable for the whole MEM state
    // ------------------------------------------------------------------
    assign dm_req            = (state == MEM);
    assign dm_req_data.we    = (ir == STDAC);
    assign dm_req_data.addr  = (ir == LDAC) ? opnd[DADDR_W-1:0] : d[DADDR_W-1:0];
    assign dm_req_data.wdata = ac;

    // ------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= FETCH;
                        pc    <= '0;  // every run starts at word 0
                    end
                end
                FETCH: begin
                    pc    <= pc + 1'b1;  // ROM sees next word during DECODE
                    state <= DECODE;
                end
                DECODE: begin
                    if (has_opnd) begin
                        pc    <= pc + 1'b1;  // step over operand
                        state <= OPERAND;
                    end else if (is_mem) begin
                        state <= MEM;
                    end else begin
                        state <= EXEC;
                    end
                end
                OPERAND: begin
                    state <= (ir == LDAC) ? MEM : EXEC;
                end
                MEM: begin
                    if (dm_ack) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (ir == ENDOP) begin
                        state <= HALT;
                    end else begin
                        if (ir == JPNZ && ac != '0) begin
                            pc <= opnd[IADDR_W-1:0];
                        end
                        state <= FETCH;
                    end
                end
                HALT: begin
                    if (!run) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // registers and ALU
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            DECODE:  ir <= dec_op;
            OPERAND: opnd <= fetch_data;
            MEM: begin
                if (dm_ack && ir != STDAC) begin
                    ac <= dm_rsp.rdata;  // load data
                end
            end
            EXEC: begin
                case (ir)
                    MVACR:   r <= ac;
                    MVACA:   a <= ac;
                    MVACB:   b <= ac;
                    MVACC:   c <= ac;
                    MVACD:   d <= ac;
                    MVA:     ac <= a;
                    MVB:     ac <= b;
                    MVC:     ac <= c;
                    MVD:     ac <= d;
                    MVCID:   ac <= DATA_W'(cid);
                    INAC:    ac <= ac + 1'b1;
                    CLAC:    ac <= '0;
                    ADD:     ac <= ac + r;
                    SUB:     ac <= ac - r;
                    MUL:     ac <= ac * r;  // low half only
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/mcp_dmem_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_dmem_arb
    import mcp_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [NUM_C-1:0]         core_req,
    input  dmem_req_t [NUM_C-1:0]    core_req_data,
    output logic [NUM_C-1:0]         core_ack,
    output dmem_rsp_t [NUM_C-1:0]    core_rsp,
    input  logic                     host_we,
    input  logic [DADDR_W-1:0]       host_addr,
    input  logic [DATA_W-1:0]        host_wdata,
    output logic [DATA_W-1:0]        host_rdata
);

    logic [DATA_W-1:0] mem [DRAM_DEPTH];
    logic [NUM_C-1:0]  pend;
    logic [NUM_C-1:0]  gnt;
    logic              last_q;   // port granted last
    logic              sel;
    dmem_req_t         sel_req;

    // new requests only, an acked port waits for its req to drop
    assign pend = core_req & ~core_ack;

    always_comb begin
        gnt = '0;
        if (pend[0] && pend[1]) begin
            sel = ~last_q;  // contention, alternate
        end else begin
            sel = pend[1];
        end
        if (|pend) begin
            gnt[sel] = 1'b1;
        end
    end

    assign sel_req = core_req_data[sel];

    // ------------------------------------------------------------------
    // grant and ack state
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            core_ack <= '0;
            last_q   <= 1'b1;  // core 0 wins first
        end else begin
            core_ack <= (core_ack & core_req) | gnt;
            if (|pend) begin
                last_q <= sel;
            end
        end
    end

    // ------------------------------------------------------------------
    // single-port RAM, cores first, host when no core asks
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (|pend) begin
            if (sel_req.we) begin
                mem[sel_req.addr] <= sel_req.wdata;
            end
            core_rsp[sel].rdata <= mem[sel_req.addr];
        end else if (host_we && core_req == '0) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];
    end

endmodule

`default_nettype wire

/* hw/mcp_iram.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_iram
    import mcp_pkg::*;
(
    input  logic                             clk,
    input  logic [NUM_C-1:0][IADDR_W-1:0]    fetch_addr,
    output logic [NUM_C-1:0][DATA_W-1:0]     fetch_data
);

    logic [DATA_W-1:0] rom [IRAM_DEPTH];
    int                wp;  // load pointer, init only

    task automatic emit(input logic [DATA_W-1:0] w);
        rom[wp] = w;
        wp++;
    endtask

    task automatic emit2(input opcode_e op, input int arg);
        emit(op);
        emit(DATA_W'(arg));
    endtask

    // ------------------------------------------------------------------
    // row-product program, row = core id
    // A holds the A-row pointer, B the B-column pointer, C the sum
    // ------------------------------------------------------------------
    initial begin
        for (int i = 0; i < IRAM_DEPTH; i++) begin
            rom[i] = NOP;
        end
        wp = 0;
        emit2(LDAC, CONST_BASE + 2);  // order
        emit(MVACR);
        emit(MVCID);
        emit(MUL);                    // row offset
        emit(MVACR);
        emit2(LDAC, CONST_BASE + 3);
        emit(ADD);
        emit(MVACA);                  // &A[row][0]
        emit2(LDAC, CONST_BASE + 4);
        emit(MVACB);                  // &B[0][0]
        // column loop, word 13
        emit(CLAC);
        emit(MVACC);
        // k loop, word 15
        emit(MVA);
        emit(MVACD);
        emit(LDDAC);                  // A[row][k]
        emit(MVACR);
        emit(MVB);
        emit(MVACD);
        emit(LDDAC);                  // B[k][j]
        emit(MUL);
        emit(MVACR);
        emit(MVC);
        emit(ADD);
        emit(MVACC);                  // sum += product
        emit(MVA);
        emit(INAC);
        emit(MVACA);
        emit2(LDAC, CONST_BASE + 2);
        emit(MVACR);
        emit(MVB);
        emit(ADD);
        emit(MVACB);                  // column stride 2
        emit2(LDAC, CONST_BASE + 2);  // end of row = A_BASE + 2*row + 2
        emit(MVACR);
        emit(MVCID);
        emit(MUL);
        emit(MVACR);
        emit2(LDAC, CONST_BASE + 3);
        emit(ADD);
        emit(MVACR);
        emit2(LDAC, CONST_BASE + 2);
        emit(ADD);
        emit(MVACR);
        emit(MVA);
        emit(SUB);
        emit2(JPNZ, 15);
        // j = B - B_BASE - 4
        emit2(LDAC, CONST_BASE + 4);
        emit(MVACR);
        emit(MVB);
        emit(SUB);
        emit(MVACD);
        emit2(LDAC, CONST_BASE + 2);
        emit(MVACR);
        emit(MVD);
        emit(SUB);
        emit(SUB);
        emit(MVACD);                  // D = j
        emit2(LDAC, CONST_BASE + 2);
        emit(MVACR);
        emit(MVCID);
        emit(MUL);
        emit(MVACR);
        emit(MVD);
        emit(ADD);
        emit(MVACR);
        emit2(LDAC, CONST_BASE + 5);
        emit(ADD);
        emit(MVACD);                  // &C[row][j]
        emit(MVC);
        emit(STDAC);
        // rewind A by 2, B by 3
        emit2(LDAC, CONST_BASE + 2);
        emit(MVACR);
        emit(MVA);
        emit(SUB);
        emit(MVACA);
        emit(MVB);
        emit(SUB);
        emit(MVACD);
        emit2(LDAC, CONST_BASE + 1);
        emit(MVACR);
        emit(MVD);
        emit(SUB);
        emit(MVACB);                  // &B[0][j+1]
        emit2(LDAC, CONST_BASE + 4);
        emit(MVACR);
        emit(MVB);
        emit(SUB);                    // j+1
        emit(MVACR);
        emit2(LDAC, CONST_BASE + 2);
        emit(SUB);                    // zero after last column
        emit2(JPNZ, 13);
        emit(ENDOP);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_C; i++) begin
            fetch_data[i] <= rom[fetch_addr[i]];
        end
    end

endmodule

`default_nettype wire

/* hw/mcp_pkg.sv */
`default_nettype none

package mcp_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int DATA_W     = 16;
    localparam int NUM_C      = 2;
    localparam int IADDR_W    = 8;
    localparam int IRAM_DEPTH = 256;
    localparam int DADDR_W    = 6;
    localparam int DRAM_DEPTH = 64;

    // data memory map
    localparam int CONST_BASE = 0;   // 0, 1, 2, A_BASE, B_BASE, C_BASE
    localparam int A_BASE     = 16;  // row-major, 4 words
    localparam int B_BASE     = 20;
    localparam int C_BASE     = 24;

    typedef enum logic [DATA_W-1:0] {
        LDAC  = 16'd5,
        MVACR = 16'd29,
        MVACC = 16'd30,
        MVA   = 16'd31,
        MVB   = 16'd32,
        MVC   = 16'd33,
        INAC  = 16'd34,
        CLAC  = 16'd35,
        ADD   = 16'd36,
        SUB   = 16'd38,
        MUL   = 16'd40,
        JPNZ  = 16'd48,
        NOP   = 16'd50,
        ENDOP = 16'd51,
        MVACA = 16'd52,
        MVACB = 16'd53,
        MVACD = 16'd54,
        LDDAC = 16'd55,
        STDAC = 16'd59,
        MVCID = 16'd64,
        MVD   = 16'd65
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        OPERAND,
        MEM,
        EXEC,
        HALT
    } core_state_e;

    typedef struct packed {
        logic               we;
        logic [DADDR_W-1:0] addr;
        logic [DATA_W-1:0]  wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } dmem_rsp_t;

endpackage

`default_nettype wire

/* hw/mcp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_top
    import mcp_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start_req,
    output logic                start_ack,
    input  logic                host_we,
    input  logic [DADDR_W-1:0]  host_addr,
    input  logic [DATA_W-1:0]   host_wdata,
    output logic [DATA_W-1:0]   host_rdata
);

    logic                             run;
    logic [NUM_C-1:0]                 halted;
    logic [NUM_C-1:0][IADDR_W-1:0]    fetch_addr;
    logic [NUM_C-1:0][DATA_W-1:0]     fetch_data;
    logic [NUM_C-1:0]                 dm_req;
    logic [NUM_C-1:0]                 dm_ack;
    dmem_req_t [NUM_C-1:0]            dm_req_data;
    dmem_rsp_t [NUM_C-1:0]            dm_rsp;

    // ------------------------------------------------------------------
    // start handshake
    // ------------------------------------------------------------------
    assign run = start_req & ~start_ack;  // cores drop to IDLE once acked

    always_ff @(posedge clk) begin
        if (rst) begin
            start_ack <= 1'b0;
        end else if (start_ack) begin
            start_ack <= start_req;
        end else begin
            start_ack <= start_req & (&halted);
        end
    end

    mcp_iram u_iram (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    mcp_core u_core0 (
        .clk         (clk),
        .rst         (rst),
        .cid         (1'b0),
        .run         (run),
        .halted      (halted[0]),
        .fetch_addr  (fetch_addr[0]),
        .fetch_data  (fetch_data[0]),
        .dm_req      (dm_req[0]),
        .dm_req_data (dm_req_data[0]),
        .dm_ack      (dm_ack[0]),
        .dm_rsp      (dm_rsp[0])
    );

    mcp_core u_core1 (
        .clk         (clk),
        .rst         (rst),
        .cid         (1'b1),
        .run         (run),
        .halted      (halted[1]),
        .fetch_addr  (fetch_addr[1]),
        .fetch_data  (fetch_data[1]),
        .dm_req      (dm_req[1]),
        .dm_req_data (dm_req_data[1]),
        .dm_ack      (dm_ack[1]),
        .dm_rsp      (dm_rsp[1])
    );

    mcp_dmem_arb u_dmem_arb (
        .clk           (clk),
        .rst           (rst),
        .core_req      (dm_req),
        .core_req_data (dm_req_data),
        .core_ack      (dm_ack),
        .core_rsp      (dm_rsp),
        .host_we       (host_we),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_rdata    (host_rdata)
    );

endmodule

`default_nettype wire

/* mcp.f */
hw/mcp_pkg.sv
hw/mcp_iram.sv
hw/mcp_core.sv
hw/mcp_dmem_arb.sv
hw/mcp_top.sv
tests/mcp_clkgen.sv
tests/mcp_props.sv
tests/mcp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mcp testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module mcp_tb -f mcp.f -o mcp_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
# a simulator error exit counts as a failed run
./obj_dir/mcp_sim > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "mcp simulation failed"; exit 1; } || echo "mcp simulation passed"

/* tests/mcp_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;  // released just after the second edge
    end

endmodule

`default_nettype wire

/* tests/mcp_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_props
    import mcp_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   start_req,
    input logic                   start_ack,
    input logic [NUM_C-1:0]       dm_req,
    input logic [NUM_C-1:0]       dm_ack,
    input dmem_req_t [NUM_C-1:0]  dm_req_data
);

    // ------------------------------------------------------------------
    // start handshake
    // ------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst) $rose(start_ack) |-> $past(start_req))
        else $error("start_ack rose without start_req");

    assert property (@(posedge clk) disable iff (rst) $fell(start_req) |=> !start_ack)
        else $error("start_ack still high one cycle after start_req fell");

    assert property (@(posedge clk) disable iff (rst) !start_req && !start_ack |=> !start_ack)
        else $error("start_ack rose while start_req was low");

    // ------------------------------------------------------------------
    // data handshake per core
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_C; i++) begin : g_port
        assert property (@(posedge clk) disable iff (rst)
            dm_req[i] && !dm_ack[i] |=> $stable(dm_req_data[i]))
            else $error("core %0d request changed while waiting for ack", i);

        // ack lingers one cycle after req drops
        assert property (@(posedge clk) disable iff (rst)
            dm_ack[i] |-> dm_req[i] || $past(dm_req[i]))
            else $error("core %0d ack high without a request", i);
    end

    assert property (@(posedge clk) disable iff (rst) !($rose(dm_ack[0]) && $rose(dm_ack[1])))
        else $error("both cores granted in the same RAM cycle");

endmodule

bind mcp_top mcp_props u_props (
    .clk         (clk),
    .rst         (rst),
    .start_req   (start_req),
    .start_ack   (start_ack),
    .dm_req      (dm_req),
    .dm_ack      (dm_ack),
    .dm_req_data (dm_req_data)
);

`default_nettype wire

/* tests/mcp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mcp_tb
    import mcp_pkg::*;
();

    localparam int NUM_RUNS    = 3;
    localparam int CLK_NS      = 8;
    localparam int ACK_CYCLES  = 1800;  // cycles allowed per run
    localparam int WATCHDOG_NS = (NUM_RUNS * 2000 + 200) * CLK_NS;

    logic                clk;
    logic                rst;
    logic                start_req;
    logic                start_ack;
    logic                host_we;
    logic [DADDR_W-1:0]  host_addr;
    logic [DATA_W-1:0]   host_wdata;
    logic [DATA_W-1:0]   host_rdata;

    logic [DATA_W-1:0]   mat_a [4];
    logic [DATA_W-1:0]   mat_b [4];
    logic [DATA_W-1:0]   mat_c [4];
    int                  errors;
    int                  checks;

    mcp_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    mcp_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .start_req  (start_req),
        .start_ack  (start_ack),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    // ------------------------------------------------------------------
    // host port tasks start and end 1 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic host_write(input int addr, input logic [DATA_W-1:0] data);
        host_we    = 1'b1;
        host_addr  = DADDR_W'(addr);
        host_wdata = data;
        @(posedge clk);
        #1;
        host_we    = 1'b0;
    endtask

    task automatic read_and_compare(input int addr, input logic [DATA_W-1:0] exp);
        host_addr = DADDR_W'(addr);
        @(posedge clk);
        #1;
        checks++;
        assert (host_rdata == exp)
        else begin
            errors++;
            $display("FAIL %0t: word %0d read %h, expected %h", $time, addr, host_rdata, exp);
        end
    endtask

    // row-by-column sum wrapping at 16 bits
    function automatic logic [DATA_W-1:0] ref_product(input int row, input int col);
        logic [DATA_W-1:0] sum;
        sum = '0;
        for (int k = 0; k < 2; k++) begin
            sum = sum + mat_a[row*2+k] * mat_b[k*2+col];
        end
        return sum;
    endfunction

    task automatic run_program(input int run_no);
        int cnt;
        cnt       = 0;
        start_req = 1'b1;
        while (!start_ack && cnt < ACK_CYCLES) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        checks++;
        assert (start_ack)
        else begin
            errors++;
            $display("run %0d: start_ack never came after %0d cycles", run_no, cnt);
        end
        start_req = 1'b0;
        cnt       = 0;
        while (start_ack && cnt < 4) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        checks++;
        assert (!start_ack)
        else begin
            errors++;
            $display("run %0d: start_ack stayed high after start_req dropped", run_no);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        start_req  = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(32'h4bee));
        wait (rst == 1'b0);
        @(posedge clk);
        #1;
        checks++;
        assert (start_ack == 1'b0)
        else begin
            errors++;
            $display("FAIL %0t: start_ack high after reset", $time);
        end
        for (int a = 40; a < 44; a++) begin  // scratch words
            host_write(a, DATA_W'(a * 16'h0101) ^ 16'ha5c3);
            read_and_compare(a, DATA_W'(a * 16'h0101) ^ 16'ha5c3);
        end
        host_write(CONST_BASE + 0, 16'd0);
        host_write(CONST_BASE + 1, 16'd1);
        host_write(CONST_BASE + 2, 16'd2);
        host_write(CONST_BASE + 3, DATA_W'(A_BASE));
        host_write(CONST_BASE + 4, DATA_W'(B_BASE));
        host_write(CONST_BASE + 5, DATA_W'(C_BASE));
        for (int run_no = 0; run_no < NUM_RUNS; run_no++) begin
            for (int i = 0; i < 4; i++) begin
                mat_a[i] = DATA_W'($urandom % 256);
                mat_b[i] = DATA_W'($urandom % 256);
            end
            for (int i = 0; i < 4; i++) begin
                mat_c[i] = ref_product(i / 2, i % 2);
            end
            for (int i = 0; i < 4; i++) begin
                host_write(A_BASE + i, mat_a[i]);
                host_write(B_BASE + i, mat_b[i]);
                host_write(C_BASE + i, ~mat_c[i]);  // stale value the cores overwrite
            end
            run_program(run_no);
            for (int i = 0; i < 4; i++) begin
                read_and_compare(C_BASE + i, mat_c[i]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
